/* files.f */
+incdir+test
verilog/csh_pkg.sv
verilog/csh_arbiter.sv
verilog/csh_ebox_timing.sv
verilog/csh_match.sv
verilog/csh_ebox_seq.sv
verilog/csh_diag.sv
verilog/csh.sv
test/csh_tb.sv

/* run_sim.sh */
#!/bin/bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module csh_tb -f files.f \
  --Mdir obj_dir -o csh_sim
./obj_dir/csh_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAILED" sim.log; then
  exit 1
fi
grep -q "TEST OK" sim.log

/* test/csh_tb_checks.svh */
// Compare tasks for the cache control sequencer testbench, one per result kind
`ifndef CSH_TB_CHECKS_SVH
`define CSH_TB_CHECKS_SVH

task automatic check_match(input string name, input csh_match_t got, input csh_match_t exp);
  if (got !== exp) begin
    $display("Error: %0t %s expected %h got %h", $time, name, exp, got);
    stop_on_failure("match decode mismatch");
  end
endtask

task automatic check_grant(input string name, input csh_grant_t got, input csh_grant_t exp);
  if (got !== exp) begin
    $display("Error: %0t %s expected %h got %h", $time, name, exp, got);
    stop_on_failure("grant mismatch");
  end
endtask

task automatic check_time(input string name, input csh_time_t got, input csh_time_t exp);
  if (got !== exp) begin
    $display("Error: %0t %s expected %h got %h", $time, name, exp, got);
    stop_on_failure("timing chain mismatch");
  end
endtask

task automatic check_status(input string name, input csh_status_t got, input csh_status_t exp);
  if (got !== exp) begin
    $display("Error: %0t %s expected %h got %h", $time, name, exp, got);
    stop_on_failure("sequencer status mismatch");
  end
endtask

task automatic check_diag(input string name, input logic [DIAG_W-1:0] got,
                          input logic [DIAG_W-1:0] exp);
  if (got !== exp) begin
    $display("Error: %0t %s expected %h got %h", $time, name, exp, got);
    stop_on_failure("diagnostic byte mismatch");
  end
endtask

task automatic check_level(input string name, input logic got, input logic exp);
  if (got !== exp) begin
    $display("Error: %0t %s expected %b got %b", $time, name, exp, got);
    stop_on_failure("level mismatch");
  end
endtask

`endif

/* test/csh_tb.sv */
// Testbench for the cache control sequencer
`timescale 1ns/1ns

module csh_tb import csh_pkg::*; ();

  localparam int RESET_CYCLES = 10;
  localparam int RAND_COUNT   = 200;
  localparam int NUM_SEQ      = 6;
  localparam int MAX_SEQ      = 60;
  localparam int MAX_WAIT     = 40;

  logic                  clk;
  logic                  reset;
  csh_req_t              req;
  csh_mem_t              mem;
  csh_dir_t              dir;
  logic                  ebox_cyc_abort;
  logic                  ac_ref;
  logic [DIAG_SEL_W-1:0] diag_sel;
  csh_grant_t            grant;
  csh_time_t             tm;
  csh_match_t            hit;
  csh_status_t           status;
  logic                  ready_to_go;
  logic [DIAG_W-1:0]     diag_data;

  // Reference state for the grant rules
  logic mb_prev;
  logic en_model;
  logic cyc_mb;
  logic cyc_e;
  logic [31:0] seed;
  logic [31:0] rnd;

  csh UUT (.*);

  always #2 clk = ~clk;

  task automatic stop_on_failure(input string what);
    $display("Failure: %s", what);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  `include "csh_tb_checks.svh"

  function automatic csh_match_t match_ref(input csh_dir_t d);
    csh_match_t m;
    logic [LRU_W-1:0] way;
    m = '0;
    way = '0;
    for (int i = 0; i < NUM_WAYS; i++) begin
      if (d.valid_match[i]) begin
        m.any_valid_match = 1'b1;
        way = LRU_W'(i);
        if (d.any_wr[i]) m.any_written_match = 1'b1;
        if (d.wd_val[i]) m.rd_found = 1'b1;
      end
    end
    m.lru_any_wr = d.any_wr[d.lru];
    m.match_hold = m.any_valid_match ? way : d.lru;
    return m;
  endfunction

  function automatic csh_grant_t grant_ref(input csh_req_t r, input logic mb_reg,
                                           input logic en, input logic rtg,
                                           input logic mbc, input logic ec);
    csh_grant_t g;
    g.mb_req_grant   = mb_reg;
    g.ebox_req_grant = r.ebox_req & en & rtg & ~mb_reg;
    g.mb_cyc         = mbc;
    g.ebox_cyc       = ec;
    return g;
  endfunction

  // Status one cycle after t2 of an EBOX reference
  function automatic csh_status_t status_ref(input csh_req_t r, input csh_match_t h,
                                             input csh_mem_t m);
    csh_status_t s;
    s = '0;
    if (r.vma_read && h.rd_found) s.mbox_resp = 1'b1;
    if (r.vma_write && !r.vma_pause && !h.any_valid_match && h.lru_any_wr &&
        m.cache_bit && !m.core_busy) begin
      s.writeback_t1   = 1'b1;
      s.ebox_retry_req = 1'b1;
    end
    return s;
  endfunction

  always @(posedge clk) begin
    if (reset) begin
      mb_prev  <= 1'b0;
      en_model <= 1'b1;
      cyc_mb   <= 1'b0;
      cyc_e    <= 1'b0;
    end else begin
      mb_prev  <= req.mb_req;
      // Core busy and the end of an EBOX writeback clear the enable
      en_model <= ~mem.core_busy & ~(cyc_e & mem.cache_to_mb_done);
      if (ready_to_go) begin
        cyc_mb <= mb_prev;
        cyc_e  <= req.ebox_req & en_model & ~mb_prev;
      end
    end
  end

  // Comparing process
  always @(negedge clk) begin
    if (!reset) begin
      check_grant("grant", grant, grant_ref(req, mb_prev, en_model, ready_to_go, cyc_mb, cyc_e));
      check_match("hit", hit, match_ref(dir));
    end
  end

  initial begin
    #(4 * (RESET_CYCLES + RAND_COUNT + NUM_SEQ * MAX_SEQ + 100));
    stop_on_failure("watchdog timeout, the run did not finish in time");
  end

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic wait_for_ebox_grant();
    int n;
    n = 0;
    @(negedge clk);
    while (!grant.ebox_req_grant) begin
      n++;
      if (n > MAX_WAIT) stop_on_failure("EBOX request was never granted");
      else @(negedge clk);
    end
  endtask

  task automatic wait_for_ready();
    int n;
    n = 0;
    @(negedge clk);
    while (!ready_to_go) begin
      n++;
      if (n > MAX_WAIT) stop_on_failure("cache never returned to ready");
      else @(negedge clk);
    end
  endtask

  // Runs one EBOX reference from grant through t3
  task automatic run_ebox_cycle(input logic writeback);
    csh_status_t exp_st;
    csh_time_t   exp_tm;
    wait_for_ebox_grant();
    exp_st = status_ref(req, match_ref(dir), mem);
    step();
    req.ebox_req = 1'b0;
    for (int i = 0; i < 4; i++) begin
      exp_tm = 4'b1000 >> i;
      @(negedge clk);
      check_time("tm", tm, exp_tm);
      check_status("status", status, (i == 3) ? exp_st : csh_status_t'('0));
      if (diag_sel == 3'd2)
        check_diag("diag_data", diag_data, {1'b0, (i == 3) ? exp_st : csh_status_t'('0)});
    end
    if (writeback) begin
      step();
      mem.cache_to_mb_done = 1'b1;
      step();
      mem.cache_to_mb_done = 1'b0;
      wait_for_ready();
    end else begin
      @(negedge clk);
      check_level("ready_to_go", ready_to_go, 1'b1);
    end
    step();
    req = '0;
  endtask

  initial begin
    clk = 1'b0;
    reset = 1'b1;
    req = '0;
    mem = '0;
    dir = '0;
    ebox_cyc_abort = 1'b0;
    ac_ref = 1'b0;
    diag_sel = '0;
    seed = 32'h1f64;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    reset = 1'b0;

    // Idle state after reset
    @(negedge clk);
    check_grant("grant", grant, '0);
    check_time("tm", tm, '0);
    check_status("status", status, '0);
    check_level("ready_to_go", ready_to_go, 1'b1);
    for (int s = 0; s < 8; s++) begin
      step();
      diag_sel = s[DIAG_SEL_W-1:0];
      @(negedge clk);
      check_diag("diag_data", diag_data, '0);
    end

    // Random directory words
    for (int n = 0; n < RAND_COUNT; n++) begin
      step();
      rnd = $random(seed);
      dir = rnd[$bits(csh_dir_t)-1:0];
    end

    // Memory buffer wins, then a read hit through the EBOX
    step();
    diag_sel = '0;
    dir = '{valid_match: 4'b0100, any_wr: 4'b0000, wd_val: 4'b0100, lru: 2'd1};
    req.mb_req = 1'b1;
    step();
    req.ebox_req = 1'b1;
    req.vma_read = 1'b1;
    repeat (8) begin
      @(negedge clk);
      check_level("ebox_req_grant", grant.ebox_req_grant, 1'b0);
    end
    step();
    req.mb_req = 1'b0;
    run_ebox_cycle(1'b0);

    // Read hit with the sequencer group on the diagnostic bus
    step();
    diag_sel = 3'd2;
    dir = '{valid_match: 4'b0010, any_wr: 4'b1000, wd_val: 4'b0011, lru: 2'd3};
    req.ebox_req = 1'b1;
    req.vma_read = 1'b1;
    run_ebox_cycle(1'b0);

    // Write miss with a written victim
    step();
    diag_sel = '0;
    dir = '{valid_match: 4'b0000, any_wr: 4'b0100, wd_val: 4'b0000, lru: 2'd2};
    mem.cache_bit = 1'b1;
    req.ebox_req = 1'b1;
    req.vma_write = 1'b1;
    run_ebox_cycle(1'b1);

    $display("TEST OK");
    $finish;
  end

endmodule

/* verilog/csh.sv */
// Cache control sequencer top level
`timescale 1ns/1ns

module csh import csh_pkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  input  csh_req_t              req,
  input  csh_mem_t              mem,
  input  csh_dir_t              dir,
  input  logic                  ebox_cyc_abort,
  input  logic                  ac_ref,
  input  logic [DIAG_SEL_W-1:0] diag_sel,
  output csh_grant_t            grant,
  output csh_time_t             tm,
  output csh_match_t            hit,
  output csh_status_t           status,
  output logic                  ready_to_go,
  output logic [DIAG_W-1:0]     diag_data
);

  logic              cycle_done;
  logic [DIAG_W-1:0] diag_arb;
  logic [DIAG_W-1:0] diag_time;
  logic [DIAG_W-1:0] diag_seq;
  logic [DIAG_W-1:0] diag_match;

  csh_arbiter arb (
    .clk         (clk),
    .reset       (reset),
    .req         (req),
    .mem         (mem),
    .cycle_done  (cycle_done),
    .tm          (tm),
    .grant       (grant),
    .ready_to_go (ready_to_go),
    .diag_arb    (diag_arb)
  );

  csh_ebox_timing timing (
    .clk            (clk),
    .reset          (reset),
    .start          (grant.ebox_req_grant),
    .ac_ref         (ac_ref),
    .ebox_cyc_abort (ebox_cyc_abort),
    .cache_idle_in  (cycle_done),
    .tm             (tm),
    .diag_time      (diag_time)
  );

  csh_match match (
    .dir        (dir),
    .hit        (hit),
    .diag_match (diag_match)
  );

  csh_ebox_seq seq (
    .clk         (clk),
    .reset       (reset),
    .req         (req),
    .mem         (mem),
    .tm          (tm),
    .hit         (hit),
    .ebox_cyc    (grant.ebox_cyc),
    .ready_to_go (ready_to_go),
    .status      (status),
    .cycle_done  (cycle_done),
    .diag_seq    (diag_seq)
  );

  csh_diag diag (
    .diag_sel   (diag_sel),
    .diag_arb   (diag_arb),
    .diag_time  (diag_time),
    .diag_seq   (diag_seq),
    .diag_match (diag_match),
    .diag_data  (diag_data)
  );

endmodule

/* verilog/csh_diag.sv */
// Diagnostic select of internal state groups onto the diagnostic bus
`timescale 1ns/1ns

module csh_diag import csh_pkg::*; (
  input  logic [DIAG_SEL_W-1:0] diag_sel,
  input  logic [DIAG_W-1:0]     diag_arb,
  input  logic [DIAG_W-1:0]     diag_time,
  input  logic [DIAG_W-1:0]     diag_seq,
  input  logic [DIAG_W-1:0]     diag_match,
  output logic [DIAG_W-1:0]     diag_data
);

  logic [DIAG_W-1:0] groups [DIAG_GROUPS];

  assign groups[0] = diag_arb;
  assign groups[1] = diag_time;
  assign groups[2] = diag_seq;
  assign groups[3] = diag_match;

  // Upper select values read as zero
  always_comb begin
    diag_data = '0;
    if (diag_sel[DIAG_SEL_W-1:DIAG_IDX_W] == '0) begin
      diag_data = groups[diag_sel[DIAG_IDX_W-1:0]];
    end
  end

endmodule

/* verilog/csh_ebox_seq.sv */
// EBOX read, write and writeback sequencing with response and retry strobes
`timescale 1ns/1ns

module csh_ebox_seq import csh_pkg::*; (
  input  logic              clk,
  input  logic              reset,
  input  csh_req_t          req,
  input  csh_mem_t          mem,
  input  csh_time_t         tm,
  input  csh_match_t        hit,
  input  logic              ebox_cyc,
  input  logic              ready_to_go,
  output csh_status_t       status,
  output logic              cycle_done,
  output logic [DIAG_W-1:0] diag_seq
);

  logic e_t2;
  logic rd_t2;
  logic rd_t2_ok;
  logic wr_t2;
  logic pause_wr_t2;
  logic victim_wb;
  logic rd_comp;
  logic retry_next_in;

  logic mbox_resp;
  logic e_core_rd_rq;
  logic one_word_rd;
  logic writeback_t1;
  logic cache_wr;
  logic ebox_wr_t4;
  logic wr_t3;
  logic one_word_wr;
  logic retry_next;
  logic e_writeback;

  // Classification point of an EBOX reference
  assign e_t2        = tm.t2 & ebox_cyc;
  assign rd_t2       = e_t2 & req.vma_read;
  assign rd_t2_ok    = rd_t2 & ~mem.core_busy;
  assign wr_t2       = e_t2 & req.vma_write & ~req.vma_pause;
  assign pause_wr_t2 = e_t2 & req.vma_write & req.vma_pause;

  // Miss whose LRU victim must go back to core first
  assign victim_wb = ~hit.any_valid_match & hit.lru_any_wr & mem.cache_bit;

  assign rd_comp = e_core_rd_rq & mem.core_data_valid;

  // Core busy or write not allowed sends the EBOX back
  assign retry_next_in = wr_t2 & ~hit.any_valid_match & mem.core_busy &
                           (~mem.cache_bit | hit.lru_any_wr) |
                         wr_t3 & ~mem.write_ok |
                         rd_t2 & ~hit.rd_found & mem.core_busy;

  always_ff @(posedge clk) begin
    if (reset) begin
      mbox_resp    <= 1'b0;
      e_core_rd_rq <= 1'b0;
      one_word_rd  <= 1'b0;
      writeback_t1 <= 1'b0;
      cache_wr     <= 1'b0;
      ebox_wr_t4   <= 1'b0;
      wr_t3        <= 1'b0;
      one_word_wr  <= 1'b0;
      retry_next   <= 1'b0;
      e_writeback  <= 1'b0;
    end else begin
      mbox_resp <= rd_t2 & hit.rd_found |
                   rd_comp |
                   wr_t3 & mem.write_ok |
                   one_word_wr & ~mem.mem_busy |
                   pause_wr_t2;

      // Core read held until the data arrives
      e_core_rd_rq <= rd_t2_ok & ~hit.rd_found & ~victim_wb |
                      e_core_rd_rq & ~mem.core_data_valid;

      // Uncached page reads only one word
      one_word_rd <= rd_t2_ok & ~hit.any_valid_match & ~mem.cache_bit |
                     one_word_rd & ~mbox_resp & ~ready_to_go;

      writeback_t1 <= e_t2 & ~pause_wr_t2 & ~mem.core_busy & victim_wb;
      e_writeback  <= writeback_t1 & ebox_cyc |
                      e_writeback & ~mem.cache_to_mb_done;

      // Hit, or allocate into a clean victim
      wr_t3 <= wr_t2 & (hit.any_valid_match | mem.cache_bit & ~hit.lru_any_wr);
      ebox_wr_t4 <= wr_t3 & ~retry_next_in;

      one_word_wr <= wr_t2 & ~hit.any_valid_match & ~mem.cache_bit & ~mem.core_busy |
                     one_word_wr & mem.mem_busy;

      cache_wr   <= rd_comp & ~one_word_rd | wr_t3 & mem.write_ok;
      retry_next <= retry_next_in;
    end
  end

  assign status.mbox_resp      = mbox_resp;
  assign status.e_core_rd_rq   = e_core_rd_rq;
  assign status.one_word_rd    = one_word_rd;
  assign status.writeback_t1   = writeback_t1;
  assign status.ebox_retry_req = ebox_cyc & writeback_t1 | retry_next;
  assign status.cache_wr       = cache_wr;
  assign status.ebox_wr_t4     = ebox_wr_t4;

  assign cycle_done = mbox_resp | retry_next | e_writeback & mem.cache_to_mb_done;

  assign diag_seq = {e_writeback, status};

endmodule

/* verilog/csh_match.sv */
// Directory match decode with hit way and victim-written select
`timescale 1ns/1ns

module csh_match import csh_pkg::*; (
  input  csh_dir_t          dir,
  output csh_match_t        hit,
  output logic [DIAG_W-1:0] diag_match
);

  logic [LRU_W-1:0] hit_way;

  assign hit.any_valid_match   = |dir.valid_match;
  assign hit.any_written_match = |(dir.valid_match & dir.any_wr);
  assign hit.rd_found          = |(dir.valid_match & dir.wd_val);

  // Written bit of the replacement candidate
  assign hit.lru_any_wr = dir.any_wr[dir.lru];

  // Highest matching way
  always_comb begin
    hit_way = '0;
    for (int i = 0; i < NUM_WAYS; i++) begin
      if (dir.valid_match[i]) begin
        hit_way = LRU_W'(i);
      end
    end
  end

  assign hit.match_hold = hit.any_valid_match ? hit_way : dir.lru;

  assign diag_match = {dir.valid_match, hit.match_hold,
                       hit.any_written_match, hit.lru_any_wr};

endmodule

/* verilog/csh_ebox_timing.sv */
// EBOX reference timing chain T0 to T3 with AC-reference and abort exits
`timescale 1ns/1ns

module csh_ebox_timing import csh_pkg::*; (
  input  logic              clk,
  input  logic              reset,
  input  logic              start,
  input  logic              ac_ref,
  input  logic              ebox_cyc_abort,
  input  logic              cache_idle_in,
  output csh_time_t         tm,
  output logic [DIAG_W-1:0] diag_time
);

  logic ac_exit;
  logic abort_exit;

  always_ff @(posedge clk) begin
    if (reset) begin
      tm         <= '0;
      ac_exit    <= 1'b0;
      abort_exit <= 1'b0;
    end else begin
      tm.t0 <= start;
      // AC references never reach memory
      tm.t1 <= tm.t0 & ~ac_ref & ~cache_idle_in;
      tm.t2 <= tm.t1 & ~ebox_cyc_abort;
      tm.t3 <= tm.t2;
      ac_exit    <= tm.t0 & ac_ref;
      abort_exit <= tm.t1 & ebox_cyc_abort;
    end
  end

  assign diag_time = {tm, ac_exit, abort_exit, start, cache_idle_in};

endmodule

/* verilog/csh_arbiter.sv */
// Request arbiter with cycle-type register, cache idle and ready-to-go
`timescale 1ns/1ns

module csh_arbiter import csh_pkg::*; (
  input  logic              clk,
  input  logic              reset,
  input  csh_req_t          req,
  input  csh_mem_t          mem,
  input  logic              cycle_done,
  input  csh_time_t         tm,
  output csh_grant_t        grant,
  output logic              ready_to_go,
  output logic [DIAG_W-1:0] diag_arb
);

  logic mb_req_r;
  logic ebox_req_en;
  logic en_clr;
  logic mb_cyc;
  logic ebox_cyc;
  logic cache_idle;
  logic done_in;
  logic done_d;
  logic mb_t1;
  logic t0_d;
  logic t1_d;
  logic chain_drop;

  // Memory buffer always wins over the EBOX
  assign grant.mb_req_grant   = mb_req_r;
  assign grant.ebox_req_grant = req.ebox_req & ebox_req_en & ready_to_go & ~mb_req_r;
  assign grant.mb_cyc         = mb_cyc;
  assign grant.ebox_cyc       = ebox_cyc;

  // End of an EBOX writeback transfer
  assign en_clr = ebox_cyc & mem.cache_to_mb_done;

  // Reference chain left early at t0 or t1
  assign chain_drop = t0_d & ~tm.t1 | t1_d & ~tm.t2;

  assign done_in = cycle_done | chain_drop | mb_t1;

  // An EBOX cycle frees the cache once its completion has reached cache idle
  assign ready_to_go = cache_idle & (~ebox_cyc | done_d);

  always_ff @(posedge clk) begin
    if (reset) begin
      mb_req_r    <= 1'b0;
      ebox_req_en <= 1'b1;
      mb_cyc      <= 1'b0;
      ebox_cyc    <= 1'b0;
      cache_idle  <= 1'b1;
      done_d      <= 1'b0;
      mb_t1       <= 1'b0;
      t0_d        <= 1'b0;
      t1_d        <= 1'b0;
    end else begin
      mb_req_r    <= req.mb_req;
      ebox_req_en <= ~mem.core_busy & ~en_clr;
      // Cycle type holds while a cycle runs
      if (ready_to_go) begin
        mb_cyc   <= grant.mb_req_grant;
        ebox_cyc <= grant.ebox_req_grant;
      end
      cache_idle <= done_in |
                    cache_idle & ~ready_to_go |
                    ready_to_go & ~grant.mb_req_grant & ~grant.ebox_req_grant;
      done_d     <= done_in;
      mb_t1      <= ready_to_go & grant.mb_req_grant;
      t0_d       <= tm.t0;
      t1_d       <= tm.t1;
    end
  end

  assign diag_arb = {mb_req_r, ~ebox_req_en, ~cache_idle, ~ready_to_go,
                     mb_cyc, ebox_cyc, mb_t1, done_d};

endmodule

/* verilog/csh_pkg.sv */
// Shared widths and bus structs for the cache control sequencer
package csh_pkg;

  // Cache geometry
  localparam int NUM_WAYS = 4;
  localparam int LRU_W    = $clog2(NUM_WAYS);

  // Diagnostic readout
  localparam int DIAG_SEL_W  = 3;
  localparam int DIAG_GROUPS = 4;
  localparam int DIAG_IDX_W  = $clog2(DIAG_GROUPS);
  localparam int DIAG_W      = 8;

  typedef logic [NUM_WAYS-1:0] way_vec_t;

  typedef struct packed {
    logic mb_req;
    logic ebox_req;
    logic vma_read;
    logic vma_write;
    logic vma_pause;
  } csh_req_t;

  typedef struct packed {
    logic core_busy;
    logic mem_busy;
    logic core_data_valid;
    logic write_ok;
    logic cache_bit;          // page may be cached
    logic cache_to_mb_done;
  } csh_mem_t;

  typedef struct packed {
    way_vec_t           valid_match;
    way_vec_t           any_wr;   // way holds written data
    way_vec_t           wd_val;
    logic [LRU_W-1:0]   lru;
  } csh_dir_t;

  typedef struct packed {
    logic mb_req_grant;
    logic ebox_req_grant;
    logic mb_cyc;
    logic ebox_cyc;
  } csh_grant_t;

  typedef struct packed {
    logic t0;
    logic t1;
    logic t2;
    logic t3;
  } csh_time_t;

  typedef struct packed {
    logic             any_valid_match;
    logic             any_written_match;
    logic             rd_found;
    logic             lru_any_wr;
    logic [LRU_W-1:0] match_hold;
  } csh_match_t;

  typedef struct packed {
    logic mbox_resp;
    logic e_core_rd_rq;
    logic one_word_rd;
    logic writeback_t1;
    logic ebox_retry_req;
    logic cache_wr;
    logic ebox_wr_t4;
  } csh_status_t;

endpackage
